// ==== common/analog_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Analog data path shared types
//////////////////////////////////////////////////////////////////////

package analog_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_CH    = 2;                    // Channel A and B
  localparam int ADC_RAW_W = 16;                   // Converter word
  localparam int ADC_DROP  = 2;                    // Reserved low bits
  localparam int SAMPLE_W  = 14;                   // Usable sample bits
  localparam int AVG_LEN   = 64;                   // Moving average window
  localparam int AVG_SHIFT = 6;                    // log2 of window
  localparam int ACC_W     = SAMPLE_W + AVG_SHIFT; // Sum never overflows

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;  // Raw ADC bus
  typedef logic signed [SAMPLE_W-1:0]  sample_t;   // Two's complement
  typedef logic        [SAMPLE_W-1:0]  dac_code_t; // Negative slope code
  typedef logic signed [ACC_W-1:0]     acc_t;      // Running sum

  // Channel pairs
  typedef struct packed {
    adc_raw_t ch_a;
    adc_raw_t ch_b;
  } raw_pair_t;

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  typedef struct packed {
    dac_code_t ch_a;
    dac_code_t ch_b;
  } dac_pair_t;

  // Config write handshake
  typedef enum logic {
    CFG_IDLE,  // Waiting for request
    CFG_ACK    // Acknowledge held until request drops
  } cfg_state_t;

  // Sign bit kept, lower bits inverted; works in either direction
  function automatic logic [SAMPLE_W-1:0] neg_slope(input logic [SAMPLE_W-1:0] val);
    return {val[SAMPLE_W-1], ~val[SAMPLE_W-2:0]};
  endfunction

endpackage

// ==== verilog/ctrl_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Loopback control register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_regs (
  input  logic adc_clk,    // Clock
  input  logic adc_rstn,   // Sync reset, active low
  input  logic cfg_req_i,  // Write request
  input  logic cfg_loop_i, // Loopback bit, stable with request
  output logic cfg_ack_o,  // Write acknowledge
  output logic loop_en_o   // Digital loopback enable
);

analog_pkg::cfg_state_t state_q;
analog_pkg::cfg_state_t state_d;
logic                   loop_q;

//////////////////////////////////////////////////////////////////////
// Four phase slave FSM
//////////////////////////////////////////////////////////////////////

always_comb begin
  state_d = state_q;
  case (state_q)
    analog_pkg::CFG_IDLE: begin
      if (cfg_req_i) begin
        state_d = analog_pkg::CFG_ACK;   // Accept write
      end
    end
    analog_pkg::CFG_ACK: begin
      if (!cfg_req_i) begin
        state_d = analog_pkg::CFG_IDLE;  // Master released
      end
    end
    default: state_d = analog_pkg::CFG_IDLE;
  endcase
end

always_ff @(posedge adc_clk) begin
  if (!adc_rstn) begin
    state_q <= analog_pkg::CFG_IDLE;
    loop_q  <= 1'b0;
  end else begin
    state_q <= state_d;
    // Bit latched on the edge that raises ack
    if ((state_q == analog_pkg::CFG_IDLE) && cfg_req_i) begin
      loop_q <= cfg_loop_i;
    end
  end
end

assign cfg_ack_o = (state_q == analog_pkg::CFG_ACK);
assign loop_en_o = loop_q;

// Request still held high when ack comes up
ack_after_req: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  $rose(cfg_ack_o) |-> cfg_req_i)
  else $error("cfg_ack_o rose while cfg_req_i was low");

endmodule

// ==== verilog/adc_frontend.sv ====
//////////////////////////////////////////////////////////////////////
// ADC input stage and loopback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adc_frontend (
  input  logic                     adc_clk,   // Clock
  input  logic                     adc_rstn,  // Sync reset, active low
  input  analog_pkg::raw_pair_t    adc_raw_i, // Raw converter words
  input  logic                     loop_en_i, // Digital loopback select
  input  analog_pkg::sample_pair_t loop_i,    // Saturated DAC-bound samples
  output analog_pkg::sample_pair_t adc_o      // Samples to the outside
);

analog_pkg::sample_pair_t adc_q;  // Converted and registered samples

//////////////////////////////////////////////////////////////////////
// Input registers
//////////////////////////////////////////////////////////////////////

// Upper 14 bits only, low bits reserved by the converter
// Neg slope code turned into two's complement before the flop
always_ff @(posedge adc_clk) begin
  if (!adc_rstn) begin
    adc_q <= '0;
  end else begin
    adc_q.ch_a <= analog_pkg::neg_slope(
      adc_raw_i.ch_a[analog_pkg::ADC_RAW_W-1:analog_pkg::ADC_DROP]);
    adc_q.ch_b <= analog_pkg::neg_slope(
      adc_raw_i.ch_b[analog_pkg::ADC_RAW_W-1:analog_pkg::ADC_DROP]);
  end
end

//////////////////////////////////////////////////////////////////////
// Loopback select
//////////////////////////////////////////////////////////////////////

// Loopback path stays combinational
// Output tracks the DAC sums in the same cycle
always_comb begin
  if (loop_en_i) begin
    adc_o = loop_i;   // DAC side looped back
  end else begin
    adc_o = adc_q;    // Normal ADC samples
  end
end

// Select comes from ctrl_regs, must be known once out of reset
loop_en_known: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  !$isunknown(loop_en_i))
  else $error("loop_en_i unknown after reset");

endmodule

// ==== dac_path/dac_channel.sv ====
//////////////////////////////////////////////////////////////////////
// DAC channel sum and moving average
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_channel (
  input  logic                adc_clk,  // Clock
  input  logic                adc_rstn, // Sync reset, active low
  input  analog_pkg::sample_t gen_i,    // Generator sample
  input  analog_pkg::sample_t ctl_i,    // Controller sample
  output analog_pkg::sample_t sat_o,    // Saturated sum
  output analog_pkg::sample_t avg_o     // Moving average
);

logic signed [analog_pkg::SAMPLE_W:0] sum;  // One extra bit, no wrap

analog_pkg::sample_t              hist [analog_pkg::AVG_LEN];  // Sample history
logic [analog_pkg::AVG_SHIFT-1:0] idx;                         // Oldest entry
analog_pkg::acc_t                 acc;                         // Sum of history

//////////////////////////////////////////////////////////////////////
// Sum and saturation
//////////////////////////////////////////////////////////////////////

assign sum = gen_i + ctl_i;  // Both sign extended

// Top two bits differ on overflow
always_comb begin
  if (sum[analog_pkg::SAMPLE_W] ^ sum[analog_pkg::SAMPLE_W-1]) begin
    // Clamp to max positive or max negative
    sat_o = {sum[analog_pkg::SAMPLE_W],
             {(analog_pkg::SAMPLE_W-1){~sum[analog_pkg::SAMPLE_W]}}};
  end else begin
    sat_o = sum[analog_pkg::SAMPLE_W-1:0];
  end
end

//////////////////////////////////////////////////////////////////////
// Moving average
//////////////////////////////////////////////////////////////////////

// Ring buffer with rotating index
// Running sum gains the newest value, drops the one it replaces
always_ff @(posedge adc_clk) begin
  if (!adc_rstn) begin
    idx <= '0;
    acc <= '0;
    for (int i = 0; i < analog_pkg::AVG_LEN; i++) begin
      hist[i] <= '0;
    end
  end else begin
    idx       <= idx + 1'b1;               // Wraps at AVG_LEN
    acc       <= acc + sat_o - hist[idx];
    hist[idx] <= sat_o;                     // Overwrite oldest
  end
end

// Arithmetic shift by AVG_SHIFT, top bits are the average
assign avg_o = acc[analog_pkg::ACC_W-1:analog_pkg::AVG_SHIFT];

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

// Full history total
function automatic analog_pkg::acc_t hist_total();
  analog_pkg::acc_t total;
  total = '0;
  for (int i = 0; i < analog_pkg::AVG_LEN; i++) begin
    total = total + hist[i];
  end
  return total;
endfunction

// Incremental sum must never drift from the history
acc_matches_hist: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  acc == hist_total())
  else $error("running sum 0x%h differs from history 0x%h", acc, hist_total());

endmodule

// ==== dac_path/dac_output.sv ====
//////////////////////////////////////////////////////////////////////
// DAC output registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_output (
  input  logic                     adc_clk,  // Clock
  input  logic                     adc_rstn, // Sync reset, active low
  input  analog_pkg::sample_pair_t avg_i,    // Averages, two's complement
  output analog_pkg::dac_pair_t    dac_o     // DAC codes, negative slope
);

analog_pkg::dac_code_t code_a;
analog_pkg::dac_code_t code_b;

//////////////////////////////////////////////////////////////////////
// Code conversion
//////////////////////////////////////////////////////////////////////

// Back to the converter's negative slope code
assign code_a = analog_pkg::neg_slope(avg_i.ch_a);
assign code_b = analog_pkg::neg_slope(avg_i.ch_b);

//////////////////////////////////////////////////////////////////////
// Output registers
//////////////////////////////////////////////////////////////////////

// Held at midscale under reset
always_ff @(posedge adc_clk) begin
  if (!adc_rstn) begin
    dac_o.ch_a <= analog_pkg::neg_slope('0);  // 14'h1FFF
    dac_o.ch_b <= analog_pkg::neg_slope('0);
  end else begin
    dac_o.ch_a <= code_a;
    dac_o.ch_b <= code_b;
  end
end

endmodule

// ==== verilog/analog_top.sv ====
//////////////////////////////////////////////////////////////////////
// Analog data path top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module analog_top (
  input  logic                     adc_clk,    // ADC clock, whole design
  input  logic                     adc_rstn,   // Sync reset, active low
  input  analog_pkg::raw_pair_t    adc_raw_i,  // Raw ADC words
  input  analog_pkg::sample_pair_t gen_i,      // Generator samples
  input  analog_pkg::sample_pair_t ctl_i,      // Controller samples
  input  logic                     cfg_req_i,  // Config write request
  input  logic                     cfg_loop_i, // Loopback bit
  output logic                     cfg_ack_o,  // Config write acknowledge
  output analog_pkg::sample_pair_t adc_o,      // ADC samples
  output analog_pkg::dac_pair_t    dac_o       // DAC codes
);

logic                     loop_en;   // From control register
analog_pkg::sample_pair_t sat_pair;  // Loopback source
analog_pkg::sample_pair_t avg_pair;  // Into output stage

// Per channel views, index 0 is channel A
analog_pkg::sample_t gen_ch [analog_pkg::NUM_CH];
analog_pkg::sample_t ctl_ch [analog_pkg::NUM_CH];
analog_pkg::sample_t sat_ch [analog_pkg::NUM_CH];
analog_pkg::sample_t avg_ch [analog_pkg::NUM_CH];

assign gen_ch[0]     = gen_i.ch_a;
assign gen_ch[1]     = gen_i.ch_b;
assign ctl_ch[0]     = ctl_i.ch_a;
assign ctl_ch[1]     = ctl_i.ch_b;
assign sat_pair.ch_a = sat_ch[0];
assign sat_pair.ch_b = sat_ch[1];
assign avg_pair.ch_a = avg_ch[0];
assign avg_pair.ch_b = avg_ch[1];

//////////////////////////////////////////////////////////////////////
// Control and ADC side
//////////////////////////////////////////////////////////////////////

ctrl_regs i_ctrl_regs (
  .adc_clk    (adc_clk   ),
  .adc_rstn   (adc_rstn  ),
  .cfg_req_i  (cfg_req_i ),
  .cfg_loop_i (cfg_loop_i),
  .cfg_ack_o  (cfg_ack_o ),
  .loop_en_o  (loop_en   )
);

adc_frontend i_adc_frontend (
  .adc_clk   (adc_clk  ),
  .adc_rstn  (adc_rstn ),
  .adc_raw_i (adc_raw_i),
  .loop_en_i (loop_en  ),
  .loop_i    (sat_pair ),  // Saturated sums fed back
  .adc_o     (adc_o    )
);

//////////////////////////////////////////////////////////////////////
// DAC side
//////////////////////////////////////////////////////////////////////

generate
  for (genvar ch = 0; ch < analog_pkg::NUM_CH; ch++) begin : for_ch
    dac_channel i_dac_channel (
      .adc_clk  (adc_clk    ),
      .adc_rstn (adc_rstn   ),
      .gen_i    (gen_ch[ch] ),
      .ctl_i    (ctl_ch[ch] ),
      .sat_o    (sat_ch[ch] ),
      .avg_o    (avg_ch[ch] )
    );
  end : for_ch
endgenerate

dac_output i_dac_output (
  .adc_clk  (adc_clk ),
  .adc_rstn (adc_rstn),
  .avg_i    (avg_pair),
  .dac_o    (dac_o   )
);

endmodule

// ==== tb/tb_analog_top.sv ====
//////////////////////////////////////////////////////////////////////
// Analog data path testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_analog_top;

localparam logic [31:0] SEED        = 32'h45dfbfcd;
localparam int          HOLD_CYCLES = 70;                       // Constant input hold
localparam int          SETTLE      = analog_pkg::AVG_LEN + 2;  // Window plus output reg
localparam int          ACK_TIMEOUT = 20;                       // Cycles per handshake edge
localparam int          MAX_S       = 2**(analog_pkg::SAMPLE_W-1) - 1;
localparam int          MIN_S       = -(2**(analog_pkg::SAMPLE_W-1));
localparam analog_pkg::dac_pair_t RST_DAC = {14'h1FFF, 14'h1FFF};  // Code of zero

logic                     adc_clk = 1'b0;
logic                     adc_rstn;
analog_pkg::raw_pair_t    adc_raw_i;
analog_pkg::sample_pair_t gen_i;
analog_pkg::sample_pair_t ctl_i;
logic                     cfg_req_i;
logic                     cfg_loop_i;
logic                     cfg_ack_o;
analog_pkg::sample_pair_t adc_o;
analog_pkg::dac_pair_t    dac_o;

// Check enables driven by the stimulus
logic raw_chk;
logic loop_chk;
logic avg_chk;
logic step_chk;

// Reference model state
analog_pkg::sample_pair_t exp_raw;          // Converted raw, one cycle late
analog_pkg::sample_pair_t exp_loop;         // Clamped sums
analog_pkg::dac_pair_t    exp_dac;          // Codes of the clamped sums
analog_pkg::sample_pair_t dec;              // dac_o back in two's complement
analog_pkg::sample_pair_t prev_dec;
logic                     rst_prev = 1'b1;  // Reset level at previous edge
int                       step_cnt = 0;     // Cycles since last step

always #4 adc_clk = ~adc_clk;  // 8 ns period

analog_top uut (
  .adc_clk    (adc_clk   ),
  .adc_rstn   (adc_rstn  ),
  .adc_raw_i  (adc_raw_i ),
  .gen_i      (gen_i     ),
  .ctl_i      (ctl_i     ),
  .cfg_req_i  (cfg_req_i ),
  .cfg_loop_i (cfg_loop_i),
  .cfg_ack_o  (cfg_ack_o ),
  .adc_o      (adc_o     ),
  .dac_o      (dac_o     )
);

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Upper 14 bits, then flip all but the sign
function automatic analog_pkg::sample_t conv_raw(input analog_pkg::adc_raw_t r);
  return analog_pkg::sample_t'(r[analog_pkg::ADC_RAW_W-1:analog_pkg::ADC_DROP] ^ 14'h1FFF);
endfunction

function automatic analog_pkg::sample_t clamp_sum(input analog_pkg::sample_t a,
                                                  input analog_pkg::sample_t b);
  int s;
  s = int'(a) + int'(b);
  if (s > MAX_S) s = MAX_S;       // Clip high
  else if (s < MIN_S) s = MIN_S;  // Clip low
  return analog_pkg::sample_t'(s);
endfunction

function automatic analog_pkg::dac_code_t to_code(input analog_pkg::sample_t s);
  return analog_pkg::dac_code_t'(s) ^ 14'h1FFF;
endfunction

function automatic analog_pkg::sample_t from_code(input analog_pkg::dac_code_t c);
  return analog_pkg::sample_t'(c ^ 14'h1FFF);
endfunction

// Never overshoots, never backs off
function automatic bit moves_toward(input analog_pkg::sample_t prev,
                                    input analog_pkg::sample_t cur,
                                    input analog_pkg::sample_t tgt);
  if (prev <= tgt) return (cur >= prev) && (cur <= tgt);
  else return (cur <= prev) && (cur >= tgt);
endfunction

assign exp_loop.ch_a = clamp_sum(gen_i.ch_a, ctl_i.ch_a);
assign exp_loop.ch_b = clamp_sum(gen_i.ch_b, ctl_i.ch_b);
assign exp_dac.ch_a  = to_code(exp_loop.ch_a);
assign exp_dac.ch_b  = to_code(exp_loop.ch_b);
assign dec.ch_a      = from_code(dac_o.ch_a);
assign dec.ch_b      = from_code(dac_o.ch_b);

always @(posedge adc_clk) begin
  rst_prev     <= adc_rstn;
  exp_raw.ch_a <= conv_raw(adc_raw_i.ch_a);
  exp_raw.ch_b <= conv_raw(adc_raw_i.ch_b);
  prev_dec     <= dec;
  if (!step_chk) step_cnt <= 0;  // Restarts with each step
  else step_cnt <= step_cnt + 1;
end

//////////////////////////////////////////////////////////////////////
// Failure reporting
//////////////////////////////////////////////////////////////////////

task automatic stop_on_failure(input string why);
  $display("%s", why);
  $display("Test FAILED");
  $fatal(1, "Simulation stopped at the first failed check");
endtask

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
  stop_on_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
endtask

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

reset_ack: assert property (@(posedge adc_clk) !rst_prev |-> !cfg_ack_o)
  else report_mismatch("cfg_ack_o", {31'h0, $sampled(cfg_ack_o)}, 32'h0);
reset_dac: assert property (@(posedge adc_clk) !rst_prev |-> dac_o == RST_DAC)
  else report_mismatch("dac_o", {4'h0, $sampled(dac_o)}, {4'h0, RST_DAC});

adc_raw_path: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  raw_chk |-> adc_o == exp_raw)
  else report_mismatch("adc_o", {4'h0, $sampled(adc_o)}, {4'h0, $sampled(exp_raw)});
adc_loop_path: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  loop_chk |-> adc_o == exp_loop)
  else report_mismatch("adc_o", {4'h0, $sampled(adc_o)}, {4'h0, $sampled(exp_loop)});

// Four phase ordering
ack_rise_req: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  $rose(cfg_ack_o) |-> cfg_req_i)
  else stop_on_failure("cfg_ack_o rose while cfg_req_i was low");
ack_fall_req: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  $fell(cfg_ack_o) |-> !cfg_req_i)
  else stop_on_failure("cfg_ack_o fell while cfg_req_i was still high");
ack_follows: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  (cfg_req_i && !cfg_ack_o) |=> cfg_ack_o)
  else stop_on_failure("cfg_ack_o did not rise one cycle after cfg_req_i");
ack_drops: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  (!cfg_req_i && cfg_ack_o) |=> !cfg_ack_o)
  else stop_on_failure("cfg_ack_o did not fall one cycle after cfg_req_i dropped");

avg_settled: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  avg_chk |-> dac_o == exp_dac)
  else report_mismatch("dac_o", {4'h0, $sampled(dac_o)}, {4'h0, $sampled(exp_dac)});
// Counter lags the step by one edge
step_reached: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  (step_chk && step_cnt >= SETTLE - 1) |-> dac_o == exp_dac)
  else report_mismatch("dac_o", {4'h0, $sampled(dac_o)}, {4'h0, $sampled(exp_dac)});

step_toward_a: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  step_chk |-> moves_toward(prev_dec.ch_a, dec.ch_a, exp_loop.ch_a))
  else stop_on_failure($sformatf("Error: dac_o.ch_a average moved away, 0x%h to 0x%h",
    $sampled(prev_dec.ch_a), $sampled(dec.ch_a)));
step_toward_b: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
  step_chk |-> moves_toward(prev_dec.ch_b, dec.ch_b, exp_loop.ch_b))
  else stop_on_failure($sformatf("Error: dac_o.ch_b average moved away, 0x%h to 0x%h",
    $sampled(prev_dec.ch_b), $sampled(dec.ch_b)));

//////////////////////////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////////////////////////

function automatic analog_pkg::sample_pair_t rand_pair();
  logic [31:0] tmp;
  tmp = $urandom();
  return tmp[27:0];
endfunction

// Magnitude 5000..8000 so two of them always clip
function automatic analog_pkg::sample_t big_sample(input bit neg);
  int mag;
  mag = 5000 + int'($urandom_range(3000));
  return neg ? analog_pkg::sample_t'(-mag) : analog_pkg::sample_t'(mag);
endfunction

task automatic pick_pair(input int r, output analog_pkg::sample_pair_t g,
                         output analog_pkg::sample_pair_t c);
  g = rand_pair();
  c = rand_pair();
  if (r < 2) begin            // Forced clipping on both rails
    g.ch_a = big_sample(r == 1);
    c.ch_a = big_sample(r == 1);
    g.ch_b = big_sample(r == 0);
    c.ch_b = big_sample(r == 0);
  end
endtask

task automatic wait_ack(input logic level);
  int  cnt;
  bit  seen;
  cnt  = 0;
  seen = 1'b0;
  while (!seen && cnt < ACK_TIMEOUT) begin
    @(posedge adc_clk);
    seen = (cfg_ack_o == level);
    cnt++;
  end
  if (!seen) stop_on_failure($sformatf("Timeout waiting for cfg_ack_o to reach %0d", level));
endtask

task automatic write_loop(input logic bit_val);
  @(posedge adc_clk);
  cfg_loop_i <= bit_val;  // Stable for the whole write
  cfg_req_i  <= 1'b1;
  wait_ack(1'b1);
  cfg_req_i  <= 1'b0;
  wait_ack(1'b0);
endtask

task automatic drive_random(input int cycles, input bit dac_too);
  repeat (cycles) begin
    @(posedge adc_clk);
    adc_raw_i <= $urandom();
    if (dac_too) begin
      gen_i <= rand_pair();
      ctl_i <= rand_pair();
    end
  end
endtask

// Step to a new constant pair, hold, then check the settled output
task automatic hold_step(input analog_pkg::sample_pair_t g, input analog_pkg::sample_pair_t c);
  @(posedge adc_clk);
  gen_i    <= g;
  ctl_i    <= c;
  step_chk <= 1'b1;
  repeat (HOLD_CYCLES - 1) @(posedge adc_clk);
  avg_chk  <= 1'b1;
  repeat (3) @(posedge adc_clk);
  avg_chk  <= 1'b0;
  step_chk <= 1'b0;
endtask

initial begin
  analog_pkg::sample_pair_t g;
  analog_pkg::sample_pair_t c;
  void'($urandom(SEED));
  adc_rstn   = 1'b0;
  adc_raw_i  = '0;
  gen_i      = '0;
  ctl_i      = '0;
  cfg_req_i  = 1'b0;
  cfg_loop_i = 1'b0;
  raw_chk    = 1'b0;
  loop_chk   = 1'b0;
  avg_chk    = 1'b0;
  step_chk   = 1'b0;
  repeat (3) @(posedge adc_clk);
  adc_rstn <= 1'b1;

  // Raw ADC path
  @(posedge adc_clk);
  raw_chk <= 1'b1;
  drive_random(50, 1'b0);
  raw_chk <= 1'b0;

  // Saturation, averaging and steps
  for (int r = 0; r < 6; r++) begin
    pick_pair(r, g, c);
    hold_step(g, c);
  end

  // Writes with random gaps to switch loopback on and off
  for (int n = 0; n < 3; n++) begin
    repeat ($urandom_range(8, 1)) @(posedge adc_clk);
    write_loop(1'b1);
    loop_chk <= 1'b1;
    drive_random(30, 1'b1);
    loop_chk <= 1'b0;
    repeat ($urandom_range(8, 1)) @(posedge adc_clk);
    write_loop(1'b0);
    raw_chk <= 1'b1;
    drive_random(30, 1'b1);
    raw_chk <= 1'b0;
  end

  repeat (2) @(posedge adc_clk);
  $display("Test OK");
  $finish;
end

endmodule

// ==== sim.f ====
common/analog_pkg.sv
verilog/ctrl_regs.sv
verilog/adc_frontend.sv
dac_path/dac_channel.sv
dac_path/dac_output.sv
verilog/analog_top.sv
tb/tb_analog_top.sv

// ==== Makefile ====
# Verilator build and run for the analog data path testbench

VERILATOR ?= verilator
TOP       ?= tb_analog_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)
